/* img_macros.svh */
`ifndef IMG_MACROS_SVH
`define IMG_MACROS_SVH

// Image geometry, kept small so a frame simulates quickly
`define IMG_W 16
`define IMG_H 12

// UART bit period in clock cycles
`define CLKS_PER_BIT 8

// Edge filter constants
`define BRIGHT_ADD 30
`define TH_HIGH    64
`define TH_LOW     24

// The TX FIFO must hold every filtered byte of one frame
`define TXF_DEPTH 256

`endif

/* img_pkg.sv */
`default_nettype none

`include "img_macros.svh"

package img_pkg;

    // Frame buffer address, wide enough for every pixel of a frame
    typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] pix_addr_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic de;
        logic sol;
        rgb_t rgb;
    } pix_stream_t;

    typedef struct packed {
        logic      we;
        pix_addr_t addr;
        rgb_t      data;
    } wr_req_t;

endpackage

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module uart_rx (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       i_rx,
    output logic [7:0]      o_byte,
    output logic            o_valid
);

    localparam int CPB   = `CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t           state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    // Two-flop synchronizer, idles at the line's mark level
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit timing: half a bit to the start centre, then whole bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= 3'd0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    if (clk_cnt == CNT_W'(CPB / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= 3'd0;
                        // A glitch shorter than half a bit is ignored
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (clk_cnt == CNT_W'(CPB - 1)) begin
                        clk_cnt   <= '0;
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == CNT_W'(CPB - 1)) begin
                        // Framing error drops the byte silently
                        o_valid <= rx_sync;
                        state   <= S_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_byte = shift_reg;

endmodule

`default_nettype wire

/* pixel_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module pixel_assembler
    import img_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] i_byte,
    input  wire logic       i_valid,
    output wr_req_t         o_wr,
    output logic            o_frame_done
);

    localparam int NUM_PIX = `IMG_W * `IMG_H;

    logic [1:0] phase;
    logic [7:0] r_hold;
    logic [7:0] g_hold;
    pix_addr_t  addr_cnt;
    logic       last_byte;
    logic       wr_we;
    pix_addr_t  wr_addr;
    rgb_t       wr_data;

    // Bytes arrive as R, G, B
    assign last_byte = i_valid && (phase == 2'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= 2'd0;
            addr_cnt     <= '0;
            wr_we        <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            wr_we        <= last_byte;
            o_frame_done <= last_byte && (addr_cnt == pix_addr_t'(NUM_PIX - 1));
            if (i_valid) phase <= last_byte ? 2'd0 : phase + 2'd1;
            if (last_byte) begin
                addr_cnt <= (addr_cnt == pix_addr_t'(NUM_PIX - 1)) ? '0 : addr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && phase == 2'd0) r_hold <= i_byte;
        if (i_valid && phase == 2'd1) g_hold <= i_byte;
        if (last_byte) begin
            wr_addr <= addr_cnt;
            wr_data <= '{r: r_hold, g: g_hold, b: i_byte};
        end
    end

    assign o_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

    a_addr_in_frame: assert property (@(posedge clk) disable iff (reset)
        addr_cnt < NUM_PIX)
        else $error("pixel_assembler: write address ran past the frame");

endmodule

`default_nettype wire

/* frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module frame_buffer
    import img_pkg::*;
(
    input  wire logic      clk,
    input  wire wr_req_t   i_wr,
    input  wire logic      i_frame_done,
    input  wire pix_addr_t i_raddr,
    output rgb_t           o_rdata,
    output logic           o_start
);

    localparam int NUM_PIX = `IMG_W * `IMG_H;

    rgb_t mem [NUM_PIX];

    always_ff @(posedge clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
        o_rdata <= mem[i_raddr];
    end

    // One cycle later the last pixel of the frame is in memory
    always_ff @(posedge clk) begin
        o_start <= i_frame_done;
    end

endmodule

`default_nettype wire

/* img_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module img_reader
    import img_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic i_start,
    input  wire rgb_t i_rdata,
    output pix_addr_t o_raddr,
    output pix_stream_t o_pix
);

    localparam int COL_W = $clog2(`IMG_W);
    localparam int ROW_W = $clog2(`IMG_H);

    logic             reading;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             col_last;
    logic             last_pix;
    logic             de_d1;
    logic             sol_d1;
    logic             pix_de;
    logic             pix_sol;
    rgb_t             pix_rgb;

    assign col_last = (col == COL_W'(`IMG_W - 1));
    assign last_pix = col_last && (row == ROW_W'(`IMG_H - 1));
    assign o_raddr  = pix_addr_t'(row * `IMG_W + col);

    always_ff @(posedge clk) begin
        if (reset) begin
            reading <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else if (i_start) begin
            reading <= 1'b1;
            col     <= '0;
            row     <= '0;
        end else if (reading) begin
            if (last_pix) reading <= 1'b0;
            if (col_last) begin
                col <= '0;
                row <= (row == ROW_W'(`IMG_H - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Flags wait out the RAM read, then everything is registered together
    always_ff @(posedge clk) begin
        if (reset) begin
            de_d1   <= 1'b0;
            sol_d1  <= 1'b0;
            pix_de  <= 1'b0;
            pix_sol <= 1'b0;
        end else begin
            de_d1   <= reading;
            sol_d1  <= reading && (col == '0);
            pix_de  <= de_d1;
            pix_sol <= sol_d1;
        end
    end

    always_ff @(posedge clk) begin
        pix_rgb <= i_rdata;
    end

    assign o_pix = '{de: pix_de, sol: pix_sol, rgb: pix_rgb};

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        i_start |-> !reading)
        else $error("img_reader: new frame started while still reading");

endmodule

`default_nettype wire

/* edge_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module edge_filter
    import img_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire pix_stream_t i_pix,
    output logic [7:0]       o_data,
    output logic             o_valid
);

    logic       s1_valid;
    logic       s1_sol;
    logic [7:0] s1_grey;
    logic       s2_valid;
    logic [7:0] s2_cur;
    logic [7:0] s2_ref;
    logic [7:0] last_bright;
    logic [9:0] grey_sum;
    logic [8:0] bright_sum;
    logic [7:0] bright;
    logic [7:0] abs_diff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1: grey = (R + 2G + B) / 4
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign grey_sum = {2'b00, i_pix.rgb.r} + {1'b0, i_pix.rgb.g, 1'b0} + {2'b00, i_pix.rgb.b};

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_sol   <= 1'b0;
        end else begin
            s1_valid <= i_pix.de;
            s1_sol   <= i_pix.de && i_pix.sol;
        end
        s1_grey <= grey_sum[9:2];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2: brightness with saturation, previous pixel on the row
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign bright_sum = {1'b0, s1_grey} + 9'(`BRIGHT_ADD);
    assign bright     = bright_sum[8] ? 8'hff : bright_sum[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
        if (s1_valid) begin
            last_bright <= bright;
            s2_cur      <= bright;
            // At a row start the pixel is its own neighbour, so the gradient is zero
            s2_ref      <= s1_sol ? bright : last_bright;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 3: horizontal gradient against two thresholds
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign abs_diff = (s2_cur >= s2_ref) ? (s2_cur - s2_ref) : (s2_ref - s2_cur);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= s2_valid;
        end
        if (abs_diff >= 8'(`TH_HIGH)) begin
            o_data <= 8'd255;
        end else if (abs_diff >= 8'(`TH_LOW)) begin
            o_data <= 8'd128;
        end else begin
            o_data <= 8'd0;
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module uart_tx (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] i_data,
    input  wire logic       i_valid,
    output logic            o_tx
);

    localparam int DEPTH  = `TXF_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BAUD_W = $clog2(`CLKS_PER_BIT);

    logic [7:0]        fifo_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;
    logic              busy;
    logic [9:0]        shift;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic              bit_end;
    logic              frame_end;

    assign bit_end   = busy && (baud_cnt == BAUD_W'(`CLKS_PER_BIT - 1));
    assign frame_end = bit_end && (bit_cnt == 4'd9);
    // Reload on the last stop-bit cycle so bytes leave back to back
    assign pop       = (!busy || frame_end) && (count != '0);

    always_ff @(posedge clk) begin
        if (i_valid) fifo_mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_valid) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({i_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Frame is stop, data LSB first, start; bit 0 drives the line
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            shift    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
        end else if (pop) begin
            busy     <= 1'b1;
            shift    <= {1'b1, fifo_mem[rd_ptr], 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
        end else if (frame_end) begin
            busy <= 1'b0;
        end else if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            shift    <= {1'b1, shift[9:1]};
        end else if (busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign o_tx = shift[0];

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        i_valid |-> (count < CNT_W'(DEPTH)))
        else $error("uart_tx: byte pushed into a full FIFO");

endmodule

`default_nettype wire

/* image_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module image_uart_top
    import img_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic i_rx,
    output logic      o_tx
);

    logic        [7:0] rx_byte;
    logic              rx_valid;
    wr_req_t           wr;
    logic              frame_done;
    logic              read_start;
    pix_addr_t         raddr;
    rgb_t              rdata;
    pix_stream_t       pix;
    logic        [7:0] filt_data;
    logic              filt_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive path into the frame buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    uart_rx uart_rx_i (
        .clk    (clk),
        .reset  (reset),
        .i_rx   (i_rx),
        .o_byte (rx_byte),
        .o_valid(rx_valid)
    );

    pixel_assembler pixel_assembler_i (
        .clk         (clk),
        .reset       (reset),
        .i_byte      (rx_byte),
        .i_valid     (rx_valid),
        .o_wr        (wr),
        .o_frame_done(frame_done)
    );

    frame_buffer frame_buffer_i (
        .clk         (clk),
        .i_wr        (wr),
        .i_frame_done(frame_done),
        .i_raddr     (raddr),
        .o_rdata     (rdata),
        .o_start     (read_start)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Readout, filter and transmit path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    img_reader img_reader_i (
        .clk    (clk),
        .reset  (reset),
        .i_start(read_start),
        .i_rdata(rdata),
        .o_raddr(raddr),
        .o_pix  (pix)
    );

    edge_filter edge_filter_i (
        .clk    (clk),
        .reset  (reset),
        .i_pix  (pix),
        .o_data (filt_data),
        .o_valid(filt_valid)
    );

    uart_tx uart_tx_i (
        .clk    (clk),
        .reset  (reset),
        .i_data (filt_data),
        .i_valid(filt_valid),
        .o_tx   (o_tx)
    );

endmodule

`default_nettype wire

/* tb_image_uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_macros.svh"

module tb_image_uart
    import img_pkg::*;
();

    localparam int CPB     = `CLKS_PER_BIT;
    localparam int NUM_PIX = `IMG_W * `IMG_H;
    // Twice the output time of one frame, plus room for the pipeline
    localparam int DRAIN_TIMEOUT = 2 * NUM_PIX * 10 * CPB + 1000;

    logic       clk;
    logic       reset;
    logic       i_rx;
    logic       o_tx;

    rgb_t       img [NUM_PIX];
    logic [7:0] rx_q [$];
    logic [7:0] exp_q [$];
    logic [7:0] got_byte;
    int         out_count;
    int         err_count;
    int         pass_tests;
    int         fail_tests;

    logic       mon_busy;
    int         mon_cnt;
    int         mon_bit;
    logic [7:0] mon_shift;

    image_uart_top image_uart_top_i (
        .clk  (clk),
        .reset(reset),
        .i_rx (i_rx),
        .o_tx (o_tx)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the filter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int brightened(input rgb_t p);
        int grey;
        grey = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
        return (grey + `BRIGHT_ADD > 255) ? 255 : grey + `BRIGHT_ADD;
    endfunction

    function automatic logic [7:0] expected_byte(input int idx);
        int diff;
        diff = 0;
        // Column 0 has no left neighbour on its row
        if (idx % `IMG_W != 0) begin
            diff = brightened(img[idx]) - brightened(img[idx - 1]);
            if (diff < 0) diff = -diff;
        end
        if (diff >= `TH_HIGH) begin
            return 8'd255;
        end else if (diff >= `TH_LOW) begin
            return 8'd128;
        end
        return 8'd0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART monitor on o_tx, sampled at the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (reset) begin
            mon_busy = 1'b0;
        end else if (!mon_busy) begin
            if (o_tx === 1'b0) begin
                mon_busy = 1'b1;
                mon_cnt  = 0;
                mon_bit  = 0;
            end
        end else begin
            mon_cnt = mon_cnt + 1;
            // Bit 0 is the start bit, bit 9 the stop bit
            if (mon_cnt == CPB / 2 + mon_bit * CPB) begin
                if (mon_bit == 0 && o_tx !== 1'b0) begin
                    $display("Start bit on o_tx was shorter than half a bit");
                    err_count++;
                    mon_busy = 1'b0;
                end else if (mon_bit >= 1 && mon_bit <= 8) begin
                    mon_shift = {o_tx, mon_shift[7:1]};
                end else if (mon_bit == 9) begin
                    if (o_tx === 1'b1) begin
                        rx_q.push_back(mon_shift);
                    end else begin
                        $display("Stop bit on o_tx was low, the byte was dropped");
                        err_count++;
                    end
                    mon_busy = 1'b0;
                end
                mon_bit = mon_bit + 1;
            end
        end
    end

    // Compare each decoded byte with the oldest expected one
    always @(posedge clk) begin
        if (rx_q.size() > 0) begin
            got_byte = rx_q.pop_front();
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Extra byte 0x%02h decoded on o_tx with no byte expected", got_byte);
                err_count++;
            end else begin
                check_value("o_tx byte", got_byte, exp_q.pop_front());
            end
        end
    end

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            i_rx = bits[k];
            repeat (CPB) @(negedge clk);
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < NUM_PIX; i++) begin
            send_byte(img[i].r);
            send_byte(img[i].g);
            send_byte(img[i].b);
        end
    endtask

    task automatic queue_expected();
        for (int i = 0; i < NUM_PIX; i++) begin
            exp_q.push_back(expected_byte(i));
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("Timed out with %0d output bytes still missing", exp_q.size());
            err_count++;
            exp_q.delete();
        end
        // A few idle byte times so that a trailing extra byte shows up
        repeat (30 * CPB) @(negedge clk);
    endtask

    task automatic run_frame();
        int count_before;
        count_before = out_count;
        queue_expected();
        send_frame();
        wait_drained();
        check_value("output byte count", out_count - count_before, NUM_PIX);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("Test %s: PASS", name);
        end else begin
            fail_tests++;
            $display("Test %s: FAIL (%0d errors)", name, err_count - errs_before);
        end
    endtask

    task automatic fill_solid(input rgb_t c);
        for (int i = 0; i < NUM_PIX; i++) img[i] = c;
    endtask

    task automatic fill_stripes();
        for (int i = 0; i < NUM_PIX; i++) begin
            img[i] = ((i % `IMG_W) % 2 == 0) ? rgb_t'(24'h000000) : rgb_t'(24'hffffff);
        end
    endtask

    // Even rows step by 40 in grey; odd rows step by 15 only after saturation
    task automatic fill_grey_pairs();
        logic [7:0] v;
        for (int i = 0; i < NUM_PIX; i++) begin
            if ((i / `IMG_W) % 2 == 0) begin
                v = ((i % `IMG_W) % 2 == 0) ? 8'd100 : 8'd140;
            end else begin
                v = ((i % `IMG_W) % 2 == 0) ? 8'd210 : 8'd250;
            end
            img[i] = '{r: v, g: v, b: v};
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_PIX; i++) begin
            img[i] = '{r: 8'($urandom), g: 8'($urandom), b: 8'($urandom)};
        end
    endtask

    initial begin
        int   errs;
        int   begin_count;
        rgb_t colour;
        clk        = 1'b0;
        reset      = 1'b1;
        i_rx       = 1'b1;
        err_count  = 0;
        out_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        void'($urandom(32'h2e9c));
        repeat (2) @(negedge clk);
        reset = 1'b0;

        errs = err_count;
        for (int k = 0; k < 50 * CPB; k++) begin
            @(negedge clk);
            if (o_tx !== 1'b1) begin
                check_value("o_tx", o_tx, 1);
                break;
            end
        end
        check_value("output byte count", out_count, 0);
        finish_test("1 idle line after reset", errs);

        errs   = err_count;
        colour = '{r: 8'($urandom), g: 8'($urandom), b: 8'($urandom)};
        fill_solid(colour);
        run_frame();
        finish_test("2 solid colour frame", errs);

        errs = err_count;
        fill_stripes();
        check_value("reference rising step", expected_byte(1), 255);
        check_value("reference falling step", expected_byte(2), 255);
        run_frame();
        finish_test("3 vertical stripes", errs);

        errs = err_count;
        fill_grey_pairs();
        check_value("reference mid step", expected_byte(1), 128);
        check_value("reference saturated step", expected_byte(`IMG_W + 1), 0);
        run_frame();
        finish_test("4 low threshold and saturation", errs);

        errs = err_count;
        fill_random();
        run_frame();
        finish_test("5 random frame", errs);

        errs        = err_count;
        begin_count = out_count;
        fill_random();
        queue_expected();
        send_frame();
        fill_random();
        queue_expected();
        send_frame();
        wait_drained();
        check_value("output byte count", out_count - begin_count, 2 * NUM_PIX);
        finish_test("6 two frames back to back", errs);

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
img_pkg.sv
uart_rx.sv
pixel_assembler.sv
frame_buffer.sv
img_reader.sv
edge_filter.sv
uart_tx.sv
image_uart_top.sv
tb_image_uart.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_image_uart
LINT_TOP  ?= image_uart_top
SEED      ?= 11932
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
